// File: hdl/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Machine word width and general register count for RV32I.
`define DECODE_XLEN 32
`define DECODE_NUM_GPR 32

// Machine-mode CSR addresses.
`define DECODE_CSR_MSTATUS 12'h300
`define DECODE_CSR_MTVEC 12'h305
`define DECODE_CSR_MEPC 12'h341
`define DECODE_CSR_MCAUSE 12'h342

`endif

// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Field widths of the 32-bit base encoding.
    localparam int INST_W = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int REG_IDX_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int FMT_W = 3;

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;
    typedef logic [FUNCT7_W-1:0] funct7_t;

    // Major opcodes handled by the decoder.
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC = 7'b0010111,
        OPC_STORE = 7'b0100011,
        OPC_OP = 7'b0110011,
        OPC_LUI = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR = 7'b1100111,
        OPC_JAL = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Format class, which selects the immediate layout.
    typedef enum logic [FMT_W-1:0] {
        FMT_NONE = 3'd0,
        FMT_R = 3'd1,
        FMT_I = 3'd2,
        FMT_S = 3'd3,
        FMT_B = 3'd4,
        FMT_U = 3'd5,
        FMT_J = 3'd6
    } fmt_e;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

`include "decode_cfg.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Packet handed over by fetch.
    typedef struct packed {
        logic [`DECODE_XLEN-1:0] pc;
        inst_t inst;
        logic intr;
        logic [`DECODE_XLEN-1:0] intr_code;
    } fetch_pkt_t;

    // Writeback from the later stages that is sampled on every edge.
    typedef struct packed {
        logic gpr_we;
        reg_idx_t rd;
        logic [`DECODE_XLEN-1:0] rd_data;
        logic csr_we;
        csr_addr_t csr_addr;
        logic [`DECODE_XLEN-1:0] csr_data;
    } wb_pkt_t;

    // Decoded packet passed on to execute.
    typedef struct packed {
        logic [`DECODE_XLEN-1:0] pc;
        opcode_e opcode;
        funct3_t funct3;
        funct7_t funct7;
        reg_idx_t rd;
        fmt_e fmt;
        logic [`DECODE_XLEN-1:0] imm;
        logic [`DECODE_XLEN-1:0] src1;
        logic [`DECODE_XLEN-1:0] src2;
        logic [`DECODE_XLEN-1:0] csr_rdata;
        logic is_csri;
        logic trap;
        logic [`DECODE_XLEN-1:0] trap_target;
    } dec_pkt_t;

endpackage

`default_nettype wire

// File: hdl/stage_handoff.sv
`default_nettype none

module stage_handoff #(
    parameter type payload_t = logic [31:0]
) (
    input wire clk,
    input wire rst,

    input wire in_valid,
    output logic in_ready,
    input wire payload_t in_data,

    output logic out_valid,
    input wire out_ready,
    output payload_t out_data,

    output logic accept
);

    logic take;
    logic give;

    assign take = in_valid && in_ready;
    assign give = out_valid && out_ready;

    // Ready stays low from the accepting edge until the held entry leaves.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready <= 1'b1;
        end else if (take) begin
            in_ready <= 1'b0;
        end else if (give) begin
            in_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (give) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= in_data;
        end
    end

    // One-cycle pulse in the cycle after a packet was taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            accept <= 1'b0;
        end else begin
            accept <= take;
        end
    end

    out_data_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

`default_nettype wire

// File: hdl/inst_decode.sv
`default_nettype none

`include "decode_cfg.svh"

module inst_decode (
    input wire pipe_pkg::fetch_pkt_t pkt,

    output isa_pkg::reg_idx_t rs1,
    output isa_pkg::reg_idx_t rs2,
    output isa_pkg::csr_addr_t csr_addr,
    input wire [`DECODE_XLEN-1:0] rs1_data,
    input wire [`DECODE_XLEN-1:0] rs2_data,

    output pipe_pkg::dec_pkt_t dec
);

    import isa_pkg::*;

    localparam int XLEN = `DECODE_XLEN;

    inst_t inst;
    opcode_e opcode;
    fmt_e fmt;
    logic [XLEN-1:0] imm;
    logic is_csri;

    assign inst = pkt.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign csr_addr = inst[31:20];

    // CSR immediate forms have funct3 bit 2 set.
    assign is_csri = (opcode == OPC_SYSTEM) && inst[14];

    always_comb begin
        case (opcode)
            OPC_OP: fmt = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: fmt = FMT_I;
            OPC_STORE: fmt = FMT_S;
            OPC_BRANCH: fmt = FMT_B;
            OPC_LUI, OPC_AUIPC: fmt = FMT_U;
            OPC_JAL: fmt = FMT_J;
            default: fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I: imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            FMT_S: imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B: imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U: imm = XLEN'($signed({inst[31:12], 12'h000}));
            FMT_J: imm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // CSR data and trap target come from the CSR file in the parent.
    always_comb begin
        dec = '0;
        dec.pc = pkt.pc;
        dec.opcode = opcode;
        dec.funct3 = inst[14:12];
        dec.funct7 = inst[31:25];
        dec.rd = inst[11:7];
        dec.fmt = fmt;
        dec.imm = imm;
        dec.src1 = is_csri ? XLEN'(inst[19:15]) : rs1_data;
        dec.src2 = rs2_data;
        dec.is_csri = is_csri;
        dec.trap = pkt.intr;
    end

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
`default_nettype none

`include "decode_cfg.svh"

module gpr_file (
    input wire clk,
    input wire rst,

    input wire isa_pkg::reg_idx_t rs1,
    input wire isa_pkg::reg_idx_t rs2,
    output logic [`DECODE_XLEN-1:0] rs1_data,
    output logic [`DECODE_XLEN-1:0] rs2_data,

    input wire pipe_pkg::wb_pkt_t wb
);

    logic [`DECODE_XLEN-1:0] regs [`DECODE_NUM_GPR];

    // Writes to x0 are dropped so that entry keeps its reset value.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DECODE_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.gpr_we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0);

endmodule

`default_nettype wire

// File: hdl/csr_file.sv
`default_nettype none

`include "decode_cfg.svh"

module csr_file (
    input wire clk,
    input wire rst,

    input wire isa_pkg::csr_addr_t csr_addr,
    output logic [`DECODE_XLEN-1:0] csr_rdata,

    input wire pipe_pkg::wb_pkt_t wb,

    input wire trap_take,
    input wire [`DECODE_XLEN-1:0] trap_pc,
    input wire [`DECODE_XLEN-1:0] trap_code,
    output logic [`DECODE_XLEN-1:0] mtvec
);

    logic [`DECODE_XLEN-1:0] mstatus;
    logic [`DECODE_XLEN-1:0] mepc;
    logic [`DECODE_XLEN-1:0] mcause;

    always_comb begin
        case (csr_addr)
            `DECODE_CSR_MSTATUS: csr_rdata = mstatus;
            `DECODE_CSR_MTVEC: csr_rdata = mtvec;
            `DECODE_CSR_MEPC: csr_rdata = mepc;
            `DECODE_CSR_MCAUSE: csr_rdata = mcause;
            default: csr_rdata = '0;
        endcase
    end

    // The trap capture comes last so it overrides a writeback to mepc or mcause.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
        end else begin
            if (wb.csr_we) begin
                case (wb.csr_addr)
                    `DECODE_CSR_MSTATUS: mstatus <= wb.csr_data;
                    `DECODE_CSR_MTVEC: mtvec <= wb.csr_data;
                    `DECODE_CSR_MEPC: mepc <= wb.csr_data;
                    `DECODE_CSR_MCAUSE: mcause <= wb.csr_data;
                    default: ;
                endcase
            end
            if (trap_take) begin
                mepc <= trap_pc;
                mcause <= trap_code;
            end
        end
    end

    // Each accepted packet may raise at most one trap.
    single_trap: assert property (@(posedge clk) disable iff (rst)
        trap_take |=> !trap_take);

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`default_nettype none

`include "decode_cfg.svh"

module decode_stage (
    input wire clk,
    input wire rst,

    input wire in_valid,
    output logic in_ready,
    input wire pipe_pkg::fetch_pkt_t in_pkt,

    output logic out_valid,
    input wire out_ready,
    output pipe_pkg::dec_pkt_t out_pkt,

    input wire pipe_pkg::wb_pkt_t wb
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_pkt_t held_pkt;
    logic held_valid;
    logic held_ready;
    logic in_accept;
    logic trap_take;

    reg_idx_t rs1;
    reg_idx_t rs2;
    csr_addr_t csr_addr;
    logic [`DECODE_XLEN-1:0] rs1_data;
    logic [`DECODE_XLEN-1:0] rs2_data;
    logic [`DECODE_XLEN-1:0] csr_rdata;
    logic [`DECODE_XLEN-1:0] mtvec;

    dec_pkt_t dec_part;
    dec_pkt_t dec_full;

    stage_handoff #(
        .payload_t(fetch_pkt_t)
    ) u_in_handoff (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_pkt),
        .out_valid(held_valid),
        .out_ready(held_ready),
        .out_data(held_pkt),
        .accept(in_accept)
    );

    inst_decode u_inst_decode (
        .pkt(held_pkt),
        .rs1(rs1),
        .rs2(rs2),
        .csr_addr(csr_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .dec(dec_part)
    );

    gpr_file u_gpr_file (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb(wb)
    );

    assign trap_take = in_accept && held_pkt.intr;

    csr_file u_csr_file (
        .clk(clk),
        .rst(rst),
        .csr_addr(csr_addr),
        .csr_rdata(csr_rdata),
        .wb(wb),
        .trap_take(trap_take),
        .trap_pc(held_pkt.pc),
        .trap_code(held_pkt.intr_code),
        .mtvec(mtvec)
    );

    always_comb begin
        dec_full = dec_part;
        dec_full.csr_rdata = csr_rdata;
        dec_full.trap_target = mtvec;
    end

    stage_handoff #(
        .payload_t(dec_pkt_t)
    ) u_out_handoff (
        .clk(clk),
        .rst(rst),
        .in_valid(held_valid),
        .in_ready(held_ready),
        .in_data(dec_full),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_pkt),
        .accept()
    );

endmodule

`default_nettype wire

// File: verif/tb_decode_stage.sv
`default_nettype none

`include "decode_cfg.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam logic [31:0] LFSR_SEED = 32'h6a116995;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    fetch_pkt_t in_pkt;
    logic out_valid;
    logic out_ready;
    dec_pkt_t out_pkt;
    wb_pkt_t wb;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic [31:0] gpr_model [32];
    logic [31:0] mstatus_model;
    logic [31:0] mtvec_model;
    logic [31:0] mepc_model;
    logic [31:0] mcause_model;
    int checks;
    int errors;
    int tests_run;

    decode_stage u_decode_stage (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_pkt(in_pkt),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_pkt(out_pkt),
        .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Finished with errors");
        $finish;
    end

    // Right-shifting Galois LFSR that steps once per random bit.
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        logic out_bit;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            out_bit = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            val = {val[30:0], out_bit};
        end
        return val;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] v, input int msb);
        logic [31:0] r;
        r = v;
        for (int i = msb + 1; i < 32; i++) begin
            r[i] = v[msb];
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [31:0] f3,
                                          input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [31:0] rs1,
                                          input logic [31:0] f3, input logic [31:0] rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic fetch_pkt_t make_pkt(input logic [31:0] inst, input logic intr);
        fetch_pkt_t p;
        p.pc = rand_bits(30) << 2;
        p.inst = inst;
        p.intr = intr;
        p.intr_code = intr ? (32'h8000_0000 | rand_bits(4)) : '0;
        return p;
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            `DECODE_CSR_MSTATUS: return mstatus_model;
            `DECODE_CSR_MTVEC: return mtvec_model;
            `DECODE_CSR_MEPC: return mepc_model;
            `DECODE_CSR_MCAUSE: return mcause_model;
            default: return '0;
        endcase
    endfunction

    // Expected decoded packet built from the RV32I encoding rules and the model state.
    function automatic dec_pkt_t expect_dec(input fetch_pkt_t p);
        dec_pkt_t d;
        logic [31:0] inst;
        logic [31:0] raw;
        inst = p.inst;
        raw = '0;
        d = '0;
        d.pc = p.pc;
        d.opcode = opcode_e'(inst[6:0]);
        d.funct3 = inst[14:12];
        d.funct7 = inst[31:25];
        d.rd = inst[11:7];
        case (inst[6:0])
            OPC_OP: d.fmt = FMT_R;
            OPC_LOAD, OPC_OP_IMM, OPC_JALR, OPC_SYSTEM: begin
                d.fmt = FMT_I;
                raw[11:0] = inst[31:20];
                d.imm = sign_extend(raw, 11);
            end
            OPC_STORE: begin
                d.fmt = FMT_S;
                raw[11:5] = inst[31:25];
                raw[4:0] = inst[11:7];
                d.imm = sign_extend(raw, 11);
            end
            OPC_BRANCH: begin
                d.fmt = FMT_B;
                raw[12] = inst[31];
                raw[11] = inst[7];
                raw[10:5] = inst[30:25];
                raw[4:1] = inst[11:8];
                d.imm = sign_extend(raw, 12);
            end
            OPC_LUI, OPC_AUIPC: begin
                d.fmt = FMT_U;
                d.imm = inst & 32'hffff_f000;
            end
            OPC_JAL: begin
                d.fmt = FMT_J;
                raw[20] = inst[31];
                raw[19:12] = inst[19:12];
                raw[11] = inst[20];
                raw[10:1] = inst[30:21];
                d.imm = sign_extend(raw, 20);
            end
            default: d.fmt = FMT_NONE;
        endcase
        d.is_csri = (inst[6:0] == OPC_SYSTEM) && inst[14];
        d.src1 = d.is_csri ? 32'(inst[19:15]) : gpr_model[inst[19:15]];
        d.src2 = gpr_model[inst[24:20]];
        d.csr_rdata = csr_model_read(inst[31:20]);
        d.trap = p.intr;
        d.trap_target = mtvec_model;
        return d;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_dec(input dec_pkt_t got, input dec_pkt_t exp);
        check_eq("out_pkt.pc", got.pc, exp.pc);
        check_eq("out_pkt.opcode", 32'(got.opcode), 32'(exp.opcode));
        check_eq("out_pkt.funct3", 32'(got.funct3), 32'(exp.funct3));
        check_eq("out_pkt.funct7", 32'(got.funct7), 32'(exp.funct7));
        check_eq("out_pkt.rd", 32'(got.rd), 32'(exp.rd));
        check_eq("out_pkt.fmt", 32'(got.fmt), 32'(exp.fmt));
        check_eq("out_pkt.imm", got.imm, exp.imm);
        check_eq("out_pkt.src1", got.src1, exp.src1);
        check_eq("out_pkt.src2", got.src2, exp.src2);
        check_eq("out_pkt.csr_rdata", got.csr_rdata, exp.csr_rdata);
        check_eq("out_pkt.is_csri", 32'(got.is_csri), 32'(exp.is_csri));
        check_eq("out_pkt.trap", 32'(got.trap), 32'(exp.trap));
        check_eq("out_pkt.trap_target", got.trap_target, exp.trap_target);
    endtask

    // The writeback port is taken on the second edge, so the write lands one cycle later.
    task automatic drive_wb(input wb_pkt_t w);
        @(posedge clk);
        wb <= w;
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic gpr_write(input reg_idx_t idx, input logic [31:0] data);
        wb_pkt_t w;
        w = '0;
        w.gpr_we = 1'b1;
        w.rd = idx;
        w.rd_data = data;
        drive_wb(w);
        if (idx != '0) begin
            gpr_model[idx] = data;
        end
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        wb_pkt_t w;
        w = '0;
        w.csr_we = 1'b1;
        w.csr_addr = addr;
        w.csr_data = data;
        drive_wb(w);
        case (addr)
            `DECODE_CSR_MSTATUS: mstatus_model = data;
            `DECODE_CSR_MTVEC: mtvec_model = data;
            `DECODE_CSR_MEPC: mepc_model = data;
            `DECODE_CSR_MCAUSE: mcause_model = data;
            default: ;
        endcase
    endtask

    task automatic send_pkt(input fetch_pkt_t p);
        @(posedge clk);
        in_pkt <= p;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic recv_pkt(output dec_pkt_t d);
        @(posedge clk);
        out_ready <= 1'b1;
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        d = out_pkt;
        @(posedge clk);
        out_ready <= 1'b0;
    endtask

    task automatic run_and_check(input fetch_pkt_t p);
        dec_pkt_t exp;
        dec_pkt_t got;
        exp = expect_dec(p);
        send_pkt(p);
        recv_pkt(got);
        compare_dec(got, exp);
        // An accepted interrupt request records its pc and cause.
        if (p.intr) begin
            mepc_model = p.pc;
            mcause_model = p.intr_code;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        $display("test %s finished, %0d error(s)", name, errors - err_before);
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_eq("in_ready", 32'(in_ready), 1);
        check_eq("out_valid", 32'(out_valid), 0);
        finish_test("reset_state", err0);
    endtask

    task automatic test_reg_ops();
        int err0;
        err0 = errors;
        gpr_write(5'd0, rand_bits(32) | 32'h1);
        for (int i = 1; i < 32; i++) begin
            gpr_write(reg_idx_t'(i), rand_bits(32));
        end
        for (int n = 0; n < 4; n++) begin
            run_and_check(make_pkt(enc_r(rand_bits(7), rand_bits(5), rand_bits(5),
                                         rand_bits(3), rand_bits(5)), 1'b0));
            run_and_check(make_pkt(enc_i(rand_bits(12), rand_bits(5), rand_bits(3),
                                         rand_bits(5), OPC_OP_IMM), 1'b0));
        end
        // Both sources on x0.
        run_and_check(make_pkt(enc_r(32'h20, 0, 0, 0, 1), 1'b0));
        run_and_check(make_pkt(enc_i(32'h800, 0, 2, 3, OPC_LOAD), 1'b0));
        finish_test("reg_ops", err0);
    endtask

    task automatic test_imm_formats();
        int err0;
        opcode_e opcs [4];
        err0 = errors;
        opcs = '{OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_JAL};
        for (int n = 0; n < 3; n++) begin
            foreach (opcs[k]) begin
                run_and_check(make_pkt((rand_bits(25) << 7) | 32'(opcs[k]), 1'b0));
            end
        end
        finish_test("imm_formats", err0);
    endtask

    task automatic test_back_pressure();
        int err0;
        fetch_pkt_t pa;
        fetch_pkt_t pb;
        dec_pkt_t exp_a;
        dec_pkt_t exp_b;
        dec_pkt_t held;
        dec_pkt_t got;
        err0 = errors;
        pa = make_pkt(enc_i(rand_bits(12), rand_bits(5), 0, rand_bits(5), OPC_OP_IMM), 1'b0);
        pb = make_pkt(enc_r(0, rand_bits(5), rand_bits(5), 7, rand_bits(5)), 1'b0);
        exp_a = expect_dec(pa);
        exp_b = expect_dec(pb);
        send_pkt(pa);
        send_pkt(pb);
        @(negedge clk);
        held = out_pkt;
        repeat (6) begin
            @(negedge clk);
            check_eq("in_ready", 32'(in_ready), 0);
            check_eq("out_valid", 32'(out_valid), 1);
            checks++;
            assert (out_pkt === held) else begin
                errors++;
                $display("error at %0t: out_pkt is %h, expected %h", $time, out_pkt, held);
            end
        end
        recv_pkt(got);
        compare_dec(got, exp_a);
        recv_pkt(got);
        compare_dec(got, exp_b);
        finish_test("back_pressure", err0);
    endtask

    task automatic test_csr_access();
        int err0;
        err0 = errors;
        csr_write(`DECODE_CSR_MTVEC, rand_bits(30) << 2);
        csr_write(`DECODE_CSR_MSTATUS, rand_bits(32));
        // A csrrs reads mtvec and a csrrwi then targets mstatus.
        run_and_check(make_pkt(enc_i(32'(`DECODE_CSR_MTVEC), rand_bits(5), 2, rand_bits(5),
                                     OPC_SYSTEM), 1'b0));
        run_and_check(make_pkt(enc_i(32'(`DECODE_CSR_MSTATUS), rand_bits(5), 5, rand_bits(5),
                                     OPC_SYSTEM), 1'b0));
        finish_test("csr_access", err0);
    endtask

    task automatic test_trap_capture();
        int err0;
        err0 = errors;
        run_and_check(make_pkt(enc_i(rand_bits(12), rand_bits(5), 0, rand_bits(5),
                                     OPC_OP_IMM), 1'b1));
        run_and_check(make_pkt(enc_i(32'(`DECODE_CSR_MEPC), 0, 2, rand_bits(5),
                                     OPC_SYSTEM), 1'b0));
        run_and_check(make_pkt(enc_i(32'(`DECODE_CSR_MCAUSE), 0, 2, rand_bits(5),
                                     OPC_SYSTEM), 1'b0));
        finish_test("trap_capture", err0);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_pkt = '0;
        out_ready = 1'b0;
        wb = '0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = '0;
        end
        mstatus_model = '0;
        mtvec_model = '0;
        mepc_model = '0;
        mcause_model = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_reg_ops();
        test_imm_formats();
        test_back_pressure();
        test_csr_access();
        test_trap_capture();

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_handoff.sv
hdl/inst_decode.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/decode_stage.sv
verif/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/stage_handoff.sv
      - hdl/inst_decode.sv
      - hdl/gpr_file.sv
      - hdl/csr_file.sv
      - hdl/decode_stage.sv
  - target: test
    files:
      - verif/tb_decode_stage.sv
